/* compile.f */
+incdir+include
hw/csma_reg_pkg.sv
hw/csma_types_pkg.sv
hw/csma_regs.sv
hw/backoff_timer.sv
hw/tx_attempt_ctrl.sv
hw/csma_tx_top.sv
verification/csma_tx_tb.sv

/* hw/backoff_timer.sv */
// Truncated binary exponential backoff timer with an LFSR slot draw
`default_nettype none

`include "csma_config.svh"

module backoff_timer
    import csma_reg_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire csma_cfg_t   cfg,
    input  wire logic        start_backoff,
    input  wire logic [4:0]  collision_count,
    output logic             backoff_active,
    output logic             backoff_complete,
    output logic [15:0]      backoff_time
);

    logic [7:0]  lfsr_q;
    logic [7:0]  lfsr_nx;
    logic [3:0]  exp_k;
    logic [15:0] slot_mask;
    logic [15:0] slots;
    logic [15:0] elapsed_q;

    // x^8 + x^6 + x^5 + x^4 + 1 style feedback, shift left
    function automatic logic [7:0] lfsr_step(input logic [7:0] cur);
        logic fb;
        fb = cur[7] ^ cur[5] ^ cur[4] ^ cur[3];
        return {cur[6:0], fb};
    endfunction

    always_comb begin
        lfsr_nx = lfsr_step(lfsr_q);
        // exponent capped so the window stops growing
        if (collision_count > 5'(`CSMA_BACKOFF_CAP)) begin
            exp_k = 4'(`CSMA_BACKOFF_CAP);
        end else begin
            exp_k = collision_count[3:0];
        end
        slot_mask = (16'd1 << exp_k) - 16'd1;
        // modulo 2^k of the freshly stepped value
        slots     = {8'd0, lfsr_nx} & slot_mask;
    end

    // LFSR only advances on a draw so sequences repeat from a given seed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= `CSMA_RST_SEED;
        end else if (cfg.seed_load) begin
            lfsr_q <= cfg.seed;
        end else if (start_backoff) begin
            lfsr_q <= lfsr_nx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            backoff_active   <= 1'b0;
            backoff_complete <= 1'b0;
            backoff_time     <= 16'd0;
            elapsed_q        <= 16'd0;
        end else begin
            backoff_complete <= 1'b0;
            if (start_backoff) begin
                // product truncated to 16 bits
                backoff_time   <= slots * cfg.slot_time;
                elapsed_q      <= 16'd0;
                backoff_active <= 1'b1;
            end else if (backoff_active) begin
                // active for backoff_time + 1 clocks in total
                if (elapsed_q < backoff_time) begin
                    elapsed_q <= elapsed_q + 16'd1;
                end else begin
                    backoff_active   <= 1'b0;
                    backoff_complete <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/csma_reg_pkg.sv */
// Register map opcodes and configuration bundle of the CSMA/CD engine
`default_nettype none

package csma_reg_pkg;

    // register select on the write port
    typedef enum logic [1:0] {
        REG_SLOT_TIME = 2'd0,
        REG_SEED      = 2'd1,
        REG_IFG       = 2'd2,
        REG_LIMIT     = 2'd3
    } csma_reg_addr_e;

    // configuration as seen by the controller and the backoff timer
    typedef struct packed {
        // backoff slot length in clocks
        logic [15:0] slot_time;
        // value loaded into the LFSR
        logic [7:0]  seed;
        // one-cycle strobe after a seed write
        logic        seed_load;
        // quiet clocks required before transmit
        logic [7:0]  ifg_cycles;
        // abort once attempts exceed this
        logic [3:0]  attempt_limit;
    } csma_cfg_t;

endpackage

`default_nettype wire

/* hw/csma_regs.sv */
// Configuration registers of the CSMA/CD engine with a seed-load strobe
`default_nettype none

`include "csma_config.svh"

module csma_regs
    import csma_reg_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           reg_we,
    input  wire csma_reg_addr_e reg_addr,
    input  wire logic [15:0]    reg_wdata,
    output csma_cfg_t           cfg
);

    logic [15:0] slot_time_q;
    logic [7:0]  seed_q;
    logic        seed_load_q;
    logic [7:0]  ifg_q;
    logic [3:0]  limit_q;

    // address decode of the write strobe
    logic we_slot;
    logic we_seed;
    logic we_ifg;
    logic we_limit;

    always_comb begin
        we_slot  = reg_we && (reg_addr == REG_SLOT_TIME);
        we_seed  = reg_we && (reg_addr == REG_SEED);
        we_ifg   = reg_we && (reg_addr == REG_IFG);
        we_limit = reg_we && (reg_addr == REG_LIMIT);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_time_q <= `CSMA_RST_SLOT;
            seed_q      <= `CSMA_RST_SEED;
            seed_load_q <= 1'b0;
            ifg_q       <= `CSMA_RST_IFG;
            limit_q     <= `CSMA_RST_LIMIT;
        end else begin
            // strobe follows the seed write by one edge, aligned with the new seed
            seed_load_q <= we_seed;
            if (we_slot) begin
                slot_time_q <= reg_wdata;
            end
            if (we_seed) begin
                seed_q <= reg_wdata[7:0];
            end
            if (we_ifg) begin
                ifg_q <= reg_wdata[7:0];
            end
            if (we_limit) begin
                limit_q <= reg_wdata[3:0];
            end
        end
    end

    always_comb begin
        cfg.slot_time     = slot_time_q;
        cfg.seed          = seed_q;
        cfg.seed_load     = seed_load_q;
        cfg.ifg_cycles    = ifg_q;
        cfg.attempt_limit = limit_q;
    end

endmodule

`default_nettype wire

/* hw/csma_tx_top.sv */
// Half-duplex CSMA/CD transmit retry engine top level
`default_nettype none

module csma_tx_top
    import csma_reg_pkg::*;
    import csma_types_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           reg_we,
    input  wire csma_reg_addr_e reg_addr,
    input  wire logic [15:0]    reg_wdata,
    input  wire logic           tx_start,
    input  wire logic [15:0]    frame_len,
    input  wire logic           crs,
    input  wire logic           collision,
    output logic                tx_en,
    output logic                jam,
    output logic                tx_done,
    output logic                tx_abort,
    output tx_status_t          status
);

    csma_cfg_t   cfg;
    logic        start_backoff;
    logic [4:0]  collision_count;
    logic        backoff_active;
    logic        backoff_complete;
    logic [15:0] backoff_time;

    csma_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .cfg       (cfg)
    );

    tx_attempt_ctrl ctrl_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg              (cfg),
        .tx_start         (tx_start),
        .frame_len        (frame_len),
        .crs              (crs),
        .collision        (collision),
        .backoff_active   (backoff_active),
        .backoff_complete (backoff_complete),
        .backoff_time     (backoff_time),
        .start_backoff    (start_backoff),
        .collision_count  (collision_count),
        .tx_en            (tx_en),
        .jam              (jam),
        .tx_done          (tx_done),
        .tx_abort         (tx_abort),
        .status           (status)
    );

    backoff_timer timer_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg              (cfg),
        .start_backoff    (start_backoff),
        .collision_count  (collision_count),
        .backoff_active   (backoff_active),
        .backoff_complete (backoff_complete),
        .backoff_time     (backoff_time)
    );

endmodule

`default_nettype wire

/* hw/csma_types_pkg.sv */
// Controller state encoding and transmit status bundle of the CSMA/CD engine
`default_nettype none

package csma_types_pkg;

    // attempt controller states
    typedef enum logic [2:0] {
        // waiting for a frame request
        ST_IDLE    = 3'd0,
        // waiting for the inter-frame gap on a quiet medium
        ST_DEFER   = 3'd1,
        // frame on the wire
        ST_XMIT    = 3'd2,
        // jam after a collision
        ST_JAM     = 3'd3,
        // waiting for the backoff timer
        ST_BACKOFF = 3'd4
    } tx_state_e;

    // status visible to software and the testbench
    typedef struct packed {
        // transmit attempts for the current frame
        logic [4:0]  attempts;
        // backoff timer running
        logic        backoff_active;
        // clocks of the last backoff draw
        logic [15:0] backoff_time;
        // a frame is in progress
        logic        busy;
    } tx_status_t;

    // a frame request is sampled in idle only
    // the status struct stays valid after done or abort
    // until the next request clears the attempt count

endpackage

`default_nettype wire

/* hw/tx_attempt_ctrl.sv */
// Transmit attempt FSM: defer, transmit, jam, backoff, retry, done and abort
`default_nettype none

`include "csma_config.svh"

module tx_attempt_ctrl
    import csma_reg_pkg::*;
    import csma_types_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire csma_cfg_t   cfg,
    input  wire logic        tx_start,
    input  wire logic [15:0] frame_len,
    input  wire logic        crs,
    input  wire logic        collision,
    input  wire logic        backoff_active,
    input  wire logic        backoff_complete,
    input  wire logic [15:0] backoff_time,
    output logic             start_backoff,
    output logic [4:0]       collision_count,
    output logic             tx_en,
    output logic             jam,
    output logic             tx_done,
    output logic             tx_abort,
    output tx_status_t       status
);

    localparam int JAM_W = $clog2(`CSMA_JAM_CYCLES + 1);

    tx_state_e        state;
    logic [7:0]       ifg_cnt;
    logic [15:0]      frame_cnt;
    logic [15:0]      frame_len_q;
    logic [JAM_W-1:0] jam_cnt;
    logic [4:0]       attempts;

    logic ifg_met;
    logic frame_last;
    logic jam_last;
    logic over_limit;

    always_comb begin
        // this quiet clock completes the gap
        ifg_met    = ({1'b0, ifg_cnt} + 9'd1) >= {1'b0, cfg.ifg_cycles};
        // a zero length still sends one clock
        frame_last = ({1'b0, frame_cnt} + 17'd1) >= {1'b0, frame_len_q};
        jam_last   = jam_cnt == JAM_W'(`CSMA_JAM_CYCLES - 1);
        over_limit = attempts > {1'b0, cfg.attempt_limit};
    end

    // frame length captured with the request
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && tx_start) begin
            frame_len_q <= frame_len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            ifg_cnt       <= 8'd0;
            frame_cnt     <= 16'd0;
            jam_cnt       <= '0;
            attempts      <= 5'd0;
            start_backoff <= 1'b0;
            tx_done       <= 1'b0;
            tx_abort      <= 1'b0;
        end else begin
            start_backoff <= 1'b0;
            tx_done       <= 1'b0;
            tx_abort      <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (tx_start) begin
                        state    <= ST_DEFER;
                        ifg_cnt  <= 8'd0;
                        attempts <= 5'd0;
                    end
                end
                ST_DEFER: begin
                    // any carrier restarts the gap
                    if (crs) begin
                        ifg_cnt <= 8'd0;
                    end else if (ifg_met) begin
                        state     <= ST_XMIT;
                        frame_cnt <= 16'd0;
                        attempts  <= attempts + 5'd1;
                    end else begin
                        ifg_cnt <= ifg_cnt + 8'd1;
                    end
                end
                ST_XMIT: begin
                    // collision wins over the last frame clock
                    if (collision) begin
                        state   <= ST_JAM;
                        jam_cnt <= '0;
                    end else if (frame_last) begin
                        state   <= ST_IDLE;
                        tx_done <= 1'b1;
                    end else begin
                        frame_cnt <= frame_cnt + 16'd1;
                    end
                end
                ST_JAM: begin
                    if (jam_last) begin
                        if (over_limit) begin
                            state    <= ST_IDLE;
                            tx_abort <= 1'b1;
                        end else begin
                            state         <= ST_BACKOFF;
                            start_backoff <= 1'b1;
                        end
                    end else begin
                        jam_cnt <= jam_cnt + 1'b1;
                    end
                end
                ST_BACKOFF: begin
                    // retry goes through a fresh gap
                    if (backoff_complete) begin
                        state   <= ST_DEFER;
                        ifg_cnt <= 8'd0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // tx_en stays up through the jam
    always_comb begin
        tx_en                 = (state == ST_XMIT) || (state == ST_JAM);
        jam                   = state == ST_JAM;
        collision_count       = attempts;
        status.attempts       = attempts;
        status.backoff_active = backoff_active;
        status.backoff_time   = backoff_time;
        status.busy           = state != ST_IDLE;
    end

endmodule

`default_nettype wire

/* include/csma_config.svh */
// CSMA/CD transmit engine constants and register reset values
`ifndef CSMA_CONFIG_SVH
`define CSMA_CONFIG_SVH

// jam sequence length in clocks after a collision
`define CSMA_JAM_CYCLES 4

// truncated binary exponential backoff, exponent never exceeds this
`define CSMA_BACKOFF_CAP 10

// slot time in clocks after reset, 512 bit times
`define CSMA_RST_SLOT 16'd512

// LFSR seed after reset, must be nonzero
`define CSMA_RST_SEED 8'h45

// inter-frame gap in quiet clocks
`define CSMA_RST_IFG 8'd12

// attempts allowed before the frame is dropped
`define CSMA_RST_LIMIT 4'd15

`endif

/* verification/csma_tx_tb.sv */
// Table-driven testbench of the CSMA/CD transmit retry engine with an LFSR backoff model
`default_nettype none

`include "csma_config.svh"

module csma_tx_tb
    import csma_reg_pkg::*;
    import csma_types_pkg::*;
();

    localparam int NUM_ROWS   = 7;
    localparam int WAIT_LIMIT = 70000;

    // one test row
    // seed2 goes to the seed register on the second defer when reseed is set
    typedef struct packed {
        logic        write_cfg;
        logic [15:0] slot_time;
        logic [7:0]  seed;
        logic [7:0]  seed2;
        logic [7:0]  ifg;
        logic [3:0]  limit;
        logic [15:0] frame_len;
        logic [4:0]  collisions;
        logic        noise;
        logic        reseed;
        logic        expect_abort;
    } test_row_t;

    logic           clk;
    logic           rst_n;
    logic           reg_we;
    csma_reg_addr_e reg_addr;
    logic [15:0]    reg_wdata;
    logic           tx_start;
    logic [15:0]    frame_len;
    logic           crs;
    logic           collision;
    logic           tx_en;
    logic           jam;
    logic           tx_done;
    logic           tx_abort;
    tx_status_t     status;

    test_row_t  rows [NUM_ROWS];
    string      names [NUM_ROWS];
    string      cur_name;
    logic [7:0] model_lfsr;
    integer     rand_seed = 55;
    int         errors = 0;

    csma_tx_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .tx_start  (tx_start),
        .frame_len (frame_len),
        .crs       (crs),
        .collision (collision),
        .tx_en     (tx_en),
        .jam       (jam),
        .tx_done   (tx_done),
        .tx_abort  (tx_abort),
        .status    (status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic test_row_t make_row(input logic wr, input int slot, input int sd,
                                           input int sd2, input int ifg, input int lim,
                                           input int flen, input int ncoll, input logic nz,
                                           input logic rs, input logic ab);
        test_row_t r;
        r.write_cfg    = wr;
        r.slot_time    = slot[15:0];
        r.seed         = sd[7:0];
        r.seed2        = sd2[7:0];
        r.ifg          = ifg[7:0];
        r.limit        = lim[3:0];
        r.frame_len    = flen[15:0];
        r.collisions   = ncoll[4:0];
        r.noise        = nz;
        r.reseed       = rs;
        r.expect_abort = ab;
        return r;
    endfunction

    // reference LFSR shifting left with taps 7 5 4 3
    function automatic logic [7:0] lfsr_advance(input logic [7:0] cur);
        logic fb;
        fb = ^{cur[7], cur[5], cur[4], cur[3]};
        return {cur[6:0], fb};
    endfunction

    // one draw of the truncated binary exponential backoff
    task automatic draw_backoff(input int attempt, input int slot, output int clocks);
        int k;
        int window;
        model_lfsr = lfsr_advance(model_lfsr);
        k = (attempt < `CSMA_BACKOFF_CAP) ? attempt : `CSMA_BACKOFF_CAP;
        window = 1 << k;
        clocks = ((int'(model_lfsr) % window) * slot) % 65536;
    endtask

    task automatic stop_with_fail();
        errors++;
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_eq(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Fail %s: %s expected %0d actual %0d", cur_name, what, expected, actual);
            stop_with_fail();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s while waiting for %s", cur_name, what);
        stop_with_fail();
    endtask

    task automatic write_reg(input csma_reg_addr_e addr, input logic [15:0] data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    // entered one clock into defer and left on the first tx_en clock
    task automatic defer_until_tx_en(input test_row_t r, input int attempt);
        int burst;
        int cnt;
        if (r.reseed && attempt == 2) begin
            // carrier held during the write so the gap starts afterwards
            crs = 1'b1;
            write_reg(REG_SEED, {8'd0, r.seed2});
            model_lfsr = r.seed2;
        end
        if (r.noise) begin
            burst = 1 + ({$random(rand_seed)} % 6);
            crs = 1'b1;
            repeat (burst) begin
                @(negedge clk);
                check_eq("tx_en under carrier", 0, tx_en);
            end
        end
        crs = 1'b0;
        @(negedge clk);
        cnt = 1;
        while (!tx_en && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!tx_en) report_timeout("tx_en after the gap");
        check_eq("quiet clocks before tx_en", r.ifg, cnt);
    endtask

    task automatic run_row(input int idx);
        test_row_t r;
        int attempt;
        int cnt;
        int expected;
        bit finished;
        bit aborted;
        r = rows[idx];
        cur_name = names[idx];
        attempt = 0;
        finished = 0;
        aborted = 0;
        if (r.write_cfg) begin
            write_reg(REG_SLOT_TIME, r.slot_time);
            write_reg(REG_SEED, {8'd0, r.seed});
            write_reg(REG_IFG, {8'd0, r.ifg});
            write_reg(REG_LIMIT, {12'd0, r.limit});
            model_lfsr = r.seed;
            @(negedge clk);
        end
        tx_start  = 1'b1;
        frame_len = r.frame_len;
        @(negedge clk);
        tx_start = 1'b0;
        while (!finished) begin
            attempt++;
            defer_until_tx_en(r, attempt);
            check_eq("attempts at transmit", attempt, status.attempts);
            check_eq("busy at transmit", 1, status.busy);
            if (attempt <= r.collisions) begin
                // collision in the second frame clock
                @(negedge clk);
                collision = 1'b1;
                @(negedge clk);
                collision = 1'b0;
                check_eq("jam after collision", 1, jam);
                cnt = 0;
                while (jam && cnt < WAIT_LIMIT) begin
                    check_eq("tx_en during jam", 1, tx_en);
                    check_eq("tx_done during jam", 0, tx_done);
                    cnt++;
                    @(negedge clk);
                end
                if (jam) report_timeout("end of jam");
                check_eq("jam clocks", `CSMA_JAM_CYCLES, cnt);
                if (attempt > r.limit) begin
                    check_eq("tx_abort after jam", 1, tx_abort);
                    @(negedge clk);
                    check_eq("tx_abort width", 0, tx_abort);
                    check_eq("busy after abort", 0, status.busy);
                    aborted = 1;
                    finished = 1;
                end else begin
                    check_eq("tx_abort after jam", 0, tx_abort);
                    @(negedge clk);
                    draw_backoff(attempt, r.slot_time, expected);
                    check_eq("backoff_active at start", 1, status.backoff_active);
                    check_eq("backoff_time", expected, status.backoff_time);
                    cnt = 0;
                    while (status.backoff_active && cnt < WAIT_LIMIT) begin
                        check_eq("tx_done during backoff", 0, tx_done);
                        cnt++;
                        @(negedge clk);
                    end
                    if (status.backoff_active) report_timeout("end of backoff");
                    check_eq("backoff_active clocks", expected + 1, cnt);
                    // complete pulse here and defer from the next edge
                    @(negedge clk);
                end
            end else begin
                cnt = 0;
                while (tx_en && cnt < WAIT_LIMIT) begin
                    check_eq("tx_done during frame", 0, tx_done);
                    cnt++;
                    @(negedge clk);
                end
                if (tx_en) report_timeout("end of frame");
                check_eq("tx_en clocks", r.frame_len, cnt);
                check_eq("tx_done after frame", 1, tx_done);
                check_eq("busy after frame", 0, status.busy);
                @(negedge clk);
                check_eq("tx_done width", 0, tx_done);
                finished = 1;
            end
        end
        check_eq("abort outcome", r.expect_abort, aborted);
    endtask

    initial begin
        rst_n      = 1'b0;
        reg_we     = 1'b0;
        reg_addr   = REG_SLOT_TIME;
        reg_wdata  = 16'd0;
        tx_start   = 1'b0;
        frame_len  = 16'd0;
        crs        = 1'b0;
        collision  = 1'b0;
        model_lfsr = `CSMA_RST_SEED;

        // wr slot seed seed2 ifg limit len collisions noise reseed abort
        rows[0] = make_row(0, `CSMA_RST_SLOT, `CSMA_RST_SEED, `CSMA_RST_SEED,
                           `CSMA_RST_IFG, `CSMA_RST_LIMIT, 20, 3, 0, 0, 0);
        names[0] = "defaults";
        rows[1] = make_row(1, 8, 'h3c, 'h3c, 6, 15, 30, 0, 1, 0, 0);
        names[1] = "clean_transmit";
        rows[2] = make_row(1, 5, 'h9a, 'h9a, 4, 15, 16, 3, 1, 0, 0);
        names[2] = "collision_backoff";
        rows[3] = make_row(1, 1, 'hb7, 'hb7, 3, 15, 8, 12, 0, 0, 0);
        names[3] = "exponent_cap";
        rows[4] = make_row(1, 3, 'h21, 'h21, 5, 2, 10, 3, 1, 0, 1);
        names[4] = "abort";
        rows[5] = make_row(1, 2, 'h5e, 'h5e, 4, 15, 6, 0, 0, 0, 0);
        names[5] = "start_after_abort";
        rows[6] = make_row(1, 4, 'h77, 'h0f, 4, 15, 12, 4, 1, 1, 0);
        names[6] = "seed_reload";

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        cur_name = "reset";
        check_eq("tx_en", 0, tx_en);
        check_eq("jam", 0, jam);
        check_eq("tx_done", 0, tx_done);
        check_eq("tx_abort", 0, tx_abort);
        check_eq("backoff_active", 0, status.backoff_active);
        check_eq("backoff_complete", 0, dut_i.timer_i.backoff_complete);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_fail();
        end
    end

endmodule

`default_nettype wire
